// ==== filelist.f ====
common/kvs_pkg.sv
logic/stream_buffer.sv
logic/kvs_mem.sv
logic/mem_arbiter.sv
hash_lookup/hash_lookup.sv
value_store/value_store.sv
logic/kvs_top.sv
test/kvs_checker.sv
test/kvs_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= kvs_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/kvs_tb.sv ====
`timescale 1ns/1ps

module kvs_tb
    import kvs_pkg::*;
();

    localparam int SEED = 32'h72e7c989;
    localparam int RAND_REQS = 200;
    // miss, set/get, overwrite, eviction, reset phase
    localparam int DIRECTED_REQS = 16;
    localparam int NUM_REQS = DIRECTED_REQS + RAND_REQS;
    localparam int TIMEOUT_CYCLES = 40 * NUM_REQS + 200;

    // resp_ready modes
    localparam int READY_ALWAYS = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_LOW = 2;

    // key for the set and overwrite steps
    localparam logic [KEY_W-1:0] KEY_A = 16'h00a5;
    // eviction pair differs in bits 0 and 6 so the fold cancels
    localparam logic [KEY_W-1:0] KEY_1 = 16'h1234;
    localparam logic [KEY_W-1:0] KEY_2 = 16'h1275;

    logic             clk;
    logic             rst;
    logic             req_valid;
    logic             req_ready;
    kvs_req_t         req;
    logic             resp_valid;
    logic             resp_ready = 1'b1;
    kvs_resp_t        resp;
    int               ready_mode = READY_ALWAYS;
    int               sent = 0;
    int               received = 0;
    int               cycles = 0;
    int               errors;
    logic [KEY_W-1:0] key_pool [16];

    kvs_top dut (
        .clk(clk),
        .rst(rst),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req(req),
        .resp_valid(resp_valid),
        .resp_ready(resp_ready),
        .resp(resp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // background drivers
    ////////////////////

    always @(negedge clk) begin
        case (ready_mode)
            READY_RANDOM: resp_ready <= 1'($urandom_range(0, 1));
            READY_LOW: resp_ready <= 1'b0;
            default: resp_ready <= 1'b1;
        endcase
    end

    // responses taken since the last reset
    always @(posedge clk) begin
        if (rst) begin
            received <= 0;
        end else if (resp_valid && resp_ready) begin
            received <= received + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles, responses still missing", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////
    // tasks
    ////////////////////

    // called on a falling edge
    task automatic apply_reset();
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        sent = 0;
    endtask

    // req_ready only moves on a rising edge so the falling edge sees it settled
    task automatic send_req(input kvs_op_t op, input logic [KEY_W-1:0] key,
                            input logic [VAL_W-1:0] value);
        req_valid = 1'b1;
        req.op = op;
        req.key = key;
        req.value = value;
        while (!req_ready) @(negedge clk);
        @(negedge clk);
        req_valid = 1'b0;
        sent++;
    endtask

    task automatic wait_for_responses();
        while (received != sent) @(negedge clk);
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    initial begin
        void'($urandom(SEED));
        rst = 1'b1;
        req_valid = 1'b0;
        req = '0;
        @(negedge clk);
        apply_reset();

        // empty table misses
        send_req(op_get, 16'h0000, 32'h0);
        send_req(op_get, 16'hbeef, 32'h0);
        wait_for_responses();

        // set then get, then overwrite
        send_req(op_set, KEY_A, 32'hcafe0001);
        send_req(op_get, KEY_A, 32'h0);
        send_req(op_set, KEY_A, 32'h0bad0002);
        send_req(op_get, KEY_A, 32'h0);
        wait_for_responses();

        // second set into the same bucket evicts the first
        send_req(op_set, KEY_1, 32'h11110001);
        send_req(op_set, KEY_2, 32'h22220002);
        send_req(op_get, KEY_1, 32'h0);
        send_req(op_get, KEY_2, 32'h0);
        wait_for_responses();

        // half the pool collides with the other half
        for (int i = 0; i < 8; i++) begin
            key_pool[i] = 16'($urandom());
            key_pool[i + 8] = key_pool[i] ^ 16'h0041;
        end
        ready_mode = READY_RANDOM;
        for (int i = 0; i < RAND_REQS; i++) begin
            send_req(kvs_op_t'(1'($urandom_range(0, 1))), key_pool[4'($urandom_range(0, 15))],
                     $urandom());
        end
        wait_for_responses();

        // stall two sets in the pipe and reset once a response waits
        ready_mode = READY_LOW;
        send_req(op_set, key_pool[0], 32'h5a5a0001);
        send_req(op_set, KEY_A, 32'h5a5a0002);
        while (!resp_valid) @(negedge clk);
        apply_reset();
        ready_mode = READY_ALWAYS;
        send_req(op_get, KEY_A, 32'h0);
        send_req(op_get, KEY_2, 32'h0);
        send_req(op_get, key_pool[0], 32'h0);
        send_req(op_get, key_pool[1], 32'h0);
        wait_for_responses();
        repeat (5) @(negedge clk);

        errors = dut.chk.resp_errors + dut.chk.valid_hold_errors
               + dut.chk.data_hold_errors + dut.chk.reset_errors;
        $display("errors: resp %0d, valid hold %0d, data hold %0d, reset %0d",
                 dut.chk.resp_errors, dut.chk.valid_hold_errors,
                 dut.chk.data_hold_errors, dut.chk.reset_errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== test/kvs_checker.sv ====
`timescale 1ns/1ps

module kvs_checker
    import kvs_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      req_valid,
    input logic      req_ready,
    input kvs_req_t  req,
    input logic      resp_valid,
    input logic      resp_ready,
    input kvs_resp_t resp
);

    // one counter per assertion, read by the testbench
    int resp_errors = 0;
    int valid_hold_errors = 0;
    int data_hold_errors = 0;
    int reset_errors = 0;

    ////////////////////
    // reference model
    ////////////////////

    // direct-mapped table, same fold as the hash table
    logic [NUM_BUCKETS-1:0] tab_valid;
    logic [KEY_W-1:0]       tab_key [NUM_BUCKETS];
    logic [VAL_W-1:0]       tab_value [NUM_BUCKETS];
    kvs_resp_t              exp_q [$];
    logic [IDX_W-1:0]       req_idx;
    logic                   req_hit;
    kvs_resp_t              exp_next;
    // queue head as seen at the next edge
    kvs_resp_t              exp_head;
    logic                   exp_avail;
    kvs_resp_t              resp_prev;

    // low six bits, middle six bits and top nibble folded together
    function automatic logic [IDX_W-1:0] bucket_of(input logic [KEY_W-1:0] key);
        return key[5:0] ^ key[11:6] ^ {2'b00, key[15:12]};
    endfunction

    assign req_idx = bucket_of(req.key);
    assign req_hit = tab_valid[req_idx] && (tab_key[req_idx] == req.key);

    // set echoes its value, get returns the stored value or zero
    always_comb begin
        exp_next.op  = req.op;
        exp_next.key = req.key;
        exp_next.hit = req_hit;
        if (req.op == op_set) begin
            exp_next.value = req.value;
        end else begin
            exp_next.value = req_hit ? tab_value[req_idx] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            tab_valid <= '0;
            exp_avail <= 1'b0;
            exp_head  <= '0;
        end else begin
            if (resp_valid && resp_ready && (exp_q.size() != 0)) begin
                void'(exp_q.pop_front());
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(exp_next);
                // a set always takes the bucket, old key is evicted
                if (req.op == op_set) begin
                    tab_valid[req_idx] <= 1'b1;
                    tab_key[req_idx]   <= req.key;
                    tab_value[req_idx] <= req.value;
                end
            end
            exp_avail <= exp_q.size() != 0;
            exp_head  <= (exp_q.size() != 0) ? exp_q[0] : '0;
        end
    end

    // last cycle's payload for the hold check
    always_ff @(posedge clk) begin
        resp_prev <= resp;
    end

    ////////////////////
    // assertions
    ////////////////////

    resp_matches: assert property (@(posedge clk) disable iff (rst)
        (resp_valid && resp_ready) |-> (exp_avail && (resp == exp_head)))
    else begin
        resp_errors++;
        if (!exp_avail) begin
            $error("response at t=%0t arrived with no request outstanding", $time);
        end else begin
            $error("FAILED t=%0t resp expected %h got %h", $time, exp_head, resp);
        end
    end

    valid_holds: assert property (@(posedge clk) disable iff (rst)
        (resp_valid && !resp_ready) |=> resp_valid)
    else begin
        valid_hold_errors++;
        $error("FAILED t=%0t resp_valid expected 1 got 0", $time);
    end

    data_holds: assert property (@(posedge clk) disable iff (rst)
        (resp_valid && !resp_ready) |=> (resp == resp_prev))
    else begin
        data_hold_errors++;
        $error("FAILED t=%0t resp expected %h got %h", $time, resp_prev, resp);
    end

    // out_buf empties on reset
    valid_low_after_reset: assert property (@(posedge clk) rst |=> !resp_valid)
    else begin
        reset_errors++;
        $error("FAILED t=%0t resp_valid expected 0 got 1", $time);
    end

endmodule

bind kvs_top kvs_checker chk (
    .clk(clk),
    .rst(rst),
    .req_valid(req_valid),
    .req_ready(req_ready),
    .req(req),
    .resp_valid(resp_valid),
    .resp_ready(resp_ready),
    .resp(resp)
);

// ==== logic/kvs_top.sv ====
`timescale 1ns/1ps

module kvs_top
    import kvs_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    output logic      req_ready,
    input  kvs_req_t  req,
    output logic      resp_valid,
    input  logic      resp_ready,
    output kvs_resp_t resp
);

    // in_buf to hash table
    logic                  hl_in_valid;
    logic                  hl_in_ready;
    kvs_req_t              hl_in_data;
    // hash table to value store
    logic                  item_valid;
    logic                  item_ready;
    lookup_item_t          item_data;
    // value store to out_buf
    logic                  vs_out_valid;
    logic                  vs_out_ready;
    kvs_resp_t             vs_out_data;
    // memory requests
    logic                  ht_mem_valid;
    logic                  ht_mem_ready;
    mem_req_t              ht_mem_req;
    logic                  ht_mem_rvalid;
    logic                  vs_mem_valid;
    logic                  vs_mem_ready;
    mem_req_t              vs_mem_req;
    logic                  vs_mem_rvalid;
    logic [VAL_W-1:0]      arb_rdata;
    // memory port
    logic                  mem_en;
    logic                  mem_wr;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [VAL_W-1:0]      mem_wdata;
    logic [VAL_W-1:0]      mem_rdata;

    ////////////////////
    // request path
    ////////////////////

    stream_buffer #(.payload_t(kvs_req_t)) in_buf (
        .clk(clk), .rst(rst),
        .in_valid(req_valid), .in_ready(req_ready), .in_data(req),
        .out_valid(hl_in_valid), .out_ready(hl_in_ready), .out_data(hl_in_data)
    );

    hash_lookup ht (
        .clk(clk), .rst(rst),
        .in_valid(hl_in_valid), .in_ready(hl_in_ready), .in_data(hl_in_data),
        .out_valid(item_valid), .out_ready(item_ready), .out_data(item_data),
        .mem_valid(ht_mem_valid), .mem_ready(ht_mem_ready), .mem_req(ht_mem_req),
        .mem_rvalid(ht_mem_rvalid), .mem_rdata(arb_rdata)
    );

    value_store vs (
        .clk(clk), .rst(rst),
        .in_valid(item_valid), .in_ready(item_ready), .in_data(item_data),
        .out_valid(vs_out_valid), .out_ready(vs_out_ready), .out_data(vs_out_data),
        .mem_valid(vs_mem_valid), .mem_ready(vs_mem_ready), .mem_req(vs_mem_req),
        .mem_rvalid(vs_mem_rvalid), .mem_rdata(arb_rdata)
    );

    stream_buffer #(.payload_t(kvs_resp_t)) out_buf (
        .clk(clk), .rst(rst),
        .in_valid(vs_out_valid), .in_ready(vs_out_ready), .in_data(vs_out_data),
        .out_valid(resp_valid), .out_ready(resp_ready), .out_data(resp)
    );

    ////////////////////
    // shared memory
    ////////////////////

    mem_arbiter arb (
        .clk(clk), .rst(rst),
        .ht_req(ht_mem_req), .ht_valid(ht_mem_valid), .ht_ready(ht_mem_ready),
        .ht_rvalid(ht_mem_rvalid),
        .vs_req(vs_mem_req), .vs_valid(vs_mem_valid), .vs_ready(vs_mem_ready),
        .vs_rvalid(vs_mem_rvalid),
        .rdata(arb_rdata),
        .mem_en(mem_en), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

    kvs_mem mem (
        .clk(clk), .en(mem_en), .wr(mem_wr), .addr(mem_addr),
        .wdata(mem_wdata), .rdata(mem_rdata)
    );

endmodule

// ==== value_store/value_store.sv ====
`timescale 1ns/1ps

module value_store
    import kvs_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  lookup_item_t     in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output kvs_resp_t        out_data,
    output logic             mem_valid,
    input  logic             mem_ready,
    output mem_req_t         mem_req,
    input  logic             mem_rvalid,
    input  logic [VAL_W-1:0] mem_rdata
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MEM,
        S_WAIT,
        S_OUT
    } state_t;

    state_t           state;
    // response under construction
    kvs_resp_t        resp;
    logic [IDX_W-1:0] idx;
    logic             in_fire;
    logic             mem_fire;
    logic             needs_mem;

    // get miss goes straight to the response
    assign needs_mem = (in_data.op == op_set) || in_data.hit;

    ////////////////////
    // handshakes
    ////////////////////

    assign in_ready = state == S_IDLE;
    assign in_fire  = in_valid && in_ready;

    assign out_valid = state == S_OUT;
    assign out_data  = resp;

    // value word follows the bucket index
    assign mem_valid     = state == S_MEM;
    assign mem_fire      = mem_valid && mem_ready;
    assign mem_req.wr    = resp.op == op_set;
    assign mem_req.addr  = MEM_ADDR_W'(VALUE_BASE + int'(idx));
    assign mem_req.wdata = resp.value;

    ////////////////////
    // control
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_fire) begin
                        state <= needs_mem ? S_MEM : S_OUT;
                    end
                end
                S_MEM: begin
                    // a write is finished once granted
                    if (mem_fire) begin
                        state <= mem_req.wr ? S_OUT : S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (mem_rvalid) begin
                        state <= S_OUT;
                    end
                end
                S_OUT: begin
                    if (out_ready) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // set echoes the new value, get starts at zero
    always_ff @(posedge clk) begin
        if (in_fire) begin
            resp.op    <= in_data.op;
            resp.key   <= in_data.key;
            resp.hit   <= in_data.hit;
            resp.value <= (in_data.op == op_set) ? in_data.value : '0;
            idx        <= in_data.idx;
        end else if ((state == S_WAIT) && mem_rvalid) begin
            resp.value <= mem_rdata;
        end
    end

endmodule

// ==== hash_lookup/hash_lookup.sv ====
`timescale 1ns/1ps

module hash_lookup
    import kvs_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    output logic             in_ready,
    input  kvs_req_t         in_data,
    output logic             out_valid,
    input  logic             out_ready,
    output lookup_item_t     out_data,
    output logic             mem_valid,
    input  logic             mem_ready,
    output mem_req_t         mem_req,
    input  logic             mem_rvalid,
    input  logic [VAL_W-1:0] mem_rdata
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD,
        S_WAIT,
        S_WR,
        S_OUT
    } state_t;

    state_t                 state;
    // one valid bit per bucket, memory itself is never cleared
    logic [NUM_BUCKETS-1:0] bucket_vld;
    lookup_item_t           item;
    // item still waiting for the value store
    logic                   item_pend;
    // bucket write of a set into an empty bucket
    logic                   wr_pend;
    logic [IDX_W-1:0]       in_idx;
    logic [VAL_W-1:0]       bucket_word;
    logic                   in_fire;
    logic                   out_fire;
    logic                   mem_fire;

    assign in_idx      = hash_index(in_data.key);
    // stored key sits in the low half, upper bits zero
    assign bucket_word = {{(VAL_W-KEY_W){1'b0}}, item.key};

    ////////////////////
    // handshakes
    ////////////////////

    assign in_ready = state == S_IDLE;
    assign in_fire  = in_valid && in_ready;

    assign out_valid = (state == S_OUT) && item_pend;
    assign out_fire  = out_valid && out_ready;
    assign out_data  = item;

    // empty-bucket set writes while the item is offered
    assign mem_valid     = (state == S_RD) || (state == S_WR) || ((state == S_OUT) && wr_pend);
    assign mem_fire      = mem_valid && mem_ready;
    assign mem_req.wr    = state != S_RD;
    assign mem_req.addr  = MEM_ADDR_W'(item.idx);
    assign mem_req.wdata = bucket_word;

    ////////////////////
    // control
    ////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            bucket_vld <= '0;
            item_pend  <= 1'b0;
            wr_pend    <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_fire) begin
                        // a set always claims the bucket, evicting any old key
                        if (in_data.op == op_set) begin
                            bucket_vld[in_idx] <= 1'b1;
                        end
                        item_pend <= 1'b1;
                        if (bucket_vld[in_idx]) begin
                            state <= S_RD;
                        end else begin
                            wr_pend <= in_data.op == op_set;
                            state   <= S_OUT;
                        end
                    end
                end
                S_RD: begin
                    if (mem_fire) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (mem_rvalid) begin
                        state <= (item.op == op_set) ? S_WR : S_OUT;
                    end
                end
                S_WR: begin
                    if (mem_fire) begin
                        state <= S_OUT;
                    end
                end
                S_OUT: begin
                    if (out_fire) begin
                        item_pend <= 1'b0;
                    end
                    if (mem_fire) begin
                        wr_pend <= 1'b0;
                    end
                    // done once item is taken and no write is left
                    if ((!item_pend || out_fire) && (!wr_pend || mem_fire)) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // item payload, hit resolved by the bucket compare
    always_ff @(posedge clk) begin
        if (in_fire) begin
            item.op    <= in_data.op;
            item.key   <= in_data.key;
            item.value <= in_data.value;
            item.idx   <= in_idx;
            item.hit   <= 1'b0;
        end else if ((state == S_WAIT) && mem_rvalid) begin
            item.hit <= mem_rdata == bucket_word;
        end
    end

endmodule

// ==== logic/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter
    import kvs_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    // hash table side
    input  mem_req_t              ht_req,
    input  logic                  ht_valid,
    output logic                  ht_ready,
    output logic                  ht_rvalid,
    // value store side
    input  mem_req_t              vs_req,
    input  logic                  vs_valid,
    output logic                  vs_ready,
    output logic                  vs_rvalid,
    // read data, shared
    output logic [VAL_W-1:0]      rdata,
    // memory port
    output logic                  mem_en,
    output logic                  mem_wr,
    output logic [MEM_ADDR_W-1:0] mem_addr,
    output logic [VAL_W-1:0]      mem_wdata,
    input  logic [VAL_W-1:0]      mem_rdata
);

    // set when the value store won the last grant
    logic     last_vs;
    logic     ht_fire;
    logic     vs_fire;
    mem_req_t sel;
    // outstanding read owner, one cycle deep
    logic     rd_ht;
    logic     rd_vs;

    ////////////////////
    // grant
    ////////////////////

    // on a tie the last winner backs off
    assign ht_ready = !(vs_valid && !last_vs);
    assign vs_ready = !(ht_valid && last_vs);

    // the two fires can never be high together
    assign ht_fire = ht_valid && ht_ready;
    assign vs_fire = vs_valid && vs_ready;

    assign sel       = vs_fire ? vs_req : ht_req;
    assign mem_en    = ht_fire || vs_fire;
    assign mem_wr    = sel.wr;
    assign mem_addr  = sel.addr;
    assign mem_wdata = sel.wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_vs <= 1'b0;
            rd_ht   <= 1'b0;
            rd_vs   <= 1'b0;
        end else begin
            if (ht_fire) begin
                last_vs <= 1'b0;
            end else if (vs_fire) begin
                last_vs <= 1'b1;
            end
            // writes return nothing
            rd_ht <= ht_fire && !ht_req.wr;
            rd_vs <= vs_fire && !vs_req.wr;
        end
    end

    ////////////////////
    // read return
    ////////////////////

    assign ht_rvalid = rd_ht;
    assign vs_rvalid = rd_vs;
    assign rdata     = mem_rdata;

endmodule

// ==== logic/kvs_mem.sv ====
`timescale 1ns/1ps

module kvs_mem
    import kvs_pkg::*;
(
    input  logic                  clk,
    input  logic                  en,
    input  logic                  wr,
    input  logic [MEM_ADDR_W-1:0] addr,
    input  logic [VAL_W-1:0]      wdata,
    output logic [VAL_W-1:0]      rdata
);

    // bucket region below VALUE_BASE, value region above
    logic [VAL_W-1:0] ram [2**MEM_ADDR_W];

    ////////////////////
    // single port
    ////////////////////

    // read data appears the cycle after en
    always_ff @(posedge clk) begin
        if (en) begin
            if (wr) begin
                ram[addr] <= wdata;
            end else begin
                rdata <= ram[addr];
            end
        end
    end

endmodule

// ==== logic/stream_buffer.sv ====
`timescale 1ns/1ps

module stream_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // two slots used as a tiny ring
    payload_t   slot [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // ready only looks at the fill level, never at out_ready
    assign in_ready  = count != 2'd2;
    assign out_valid = count != 2'd0;
    assign out_data  = slot[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            count <= count + 2'(push) - 2'(pop);
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (push) begin
            slot[wr_ptr] <= in_data;
        end
    end

endmodule

// ==== common/kvs_pkg.sv ====
package kvs_pkg;

    ////////////////////
    // widths and counts
    ////////////////////

    // request key and stored value
    localparam int KEY_W = 16;
    // value width, also one memory word
    localparam int VAL_W = 32;

    // direct-mapped table, one entry per bucket
    localparam int IDX_W = 6;
    localparam int NUM_BUCKETS = 64;

    // words 0..63 hold bucket keys, 64..127 hold values
    localparam int VALUE_BASE = 64;
    localparam int MEM_ADDR_W = 7;

    ////////////////////
    // stream types
    ////////////////////

    typedef enum logic {
        op_get = 1'b0,
        op_set = 1'b1
    } kvs_op_t;

    // request from the client, 49 bits
    typedef struct packed {
        kvs_op_t          op;
        logic [KEY_W-1:0] key;
        logic [VAL_W-1:0] value;
    } kvs_req_t;

    // response to the client, 50 bits
    typedef struct packed {
        kvs_op_t          op;
        logic [KEY_W-1:0] key;
        logic             hit;
        logic [VAL_W-1:0] value;
    } kvs_resp_t;

    // hash table result handed on to the value store
    typedef struct packed {
        kvs_op_t          op;
        logic [KEY_W-1:0] key;
        logic [VAL_W-1:0] value;
        logic [IDX_W-1:0] idx;
        logic             hit;
    } lookup_item_t;

    // one memory command, 40 bits
    typedef struct packed {
        logic                  wr;
        logic [MEM_ADDR_W-1:0] addr;
        logic [VAL_W-1:0]      wdata;
    } mem_req_t;

    ////////////////////
    // hash
    ////////////////////

    // fold the key into six bits, top nibble zero-extended
    function automatic logic [IDX_W-1:0] hash_index(input logic [KEY_W-1:0] key);
        return key[5:0] ^ key[11:6] ^ {2'b00, key[15:12]};
    endfunction

endpackage
